//--- compile.f
hdl/uplink_frame_pkg.sv
hdl/uplink_reg_pkg.sv
hdl/crc16_d16.sv
hdl/frame_fifo.sv
hdl/uplink_cfg_apb.sv
hdl/frame_builder.sv
hdl/uplink_top.sv
tests/tb_uplink.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the uplink testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_uplink -f compile.f -o tb_uplink_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_uplink_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "All tests passed" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- tests/tb_uplink.sv
// --------------------------------------------------
// Uplink frame generator testbench
// Directed tests for the registers, frame format,
// sequencing, back-pressure and disable
// --------------------------------------------------
`timescale 1ns/1ns

module tb_uplink;

    localparam int TEST_PERIOD  = 60;
    localparam int WORD_TIMEOUT = 1000;
    localparam int APB_TIMEOUT  = 16;
    localparam int QUIET_CYCLES = 4 * TEST_PERIOD;
    localparam int DROP_POLLS   = 200;
    localparam int NW           = uplink_frame_pkg::FRAME_WORDS;
    localparam int PAIR_BYTES   = 4 * uplink_frame_pkg::PAYLOAD_WORDS / uplink_frame_pkg::N_CHN;

    logic                          clk_sys;
    logic                          rst_sys_n;
    logic                          psel;
    logic                          penable;
    logic                          pwrite;
    logic [3:0]                    paddr;
    logic [31:0]                   pwdata;
    logic [31:0]                   prdata;
    logic                          pready;
    logic                          pslverr;
    logic [31:0]                   mdu_status;
    uplink_frame_pkg::chn_sample_t chn_samples [uplink_frame_pkg::N_CHN];
    logic                          out_ready;
    logic                          out_valid;
    uplink_frame_pkg::frame_word_t out_word;

    integer                        seed;
    logic [15:0]                   exp_seq;
    logic [3:0]                    slot_val;
    uplink_frame_pkg::frame_word_t got_words [NW];
    uplink_frame_pkg::frame_word_t exp_words [NW];

    uplink_top i_dut (
        .clk_sys, .rst_sys_n, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr, .mdu_status, .chn_samples,
        .out_ready, .out_valid, .out_word
    );

    initial begin
        clk_sys = 1'b0;
        forever #50 clk_sys = ~clk_sys;
    end

    // --------------------------------------------------
    // Error handling and compare tasks
    // --------------------------------------------------
    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic compare_word(input string name, input uplink_frame_pkg::frame_word_t exp,
                                input uplink_frame_pkg::frame_word_t act);
        if (act !== exp) begin
            stop_run($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic compare_reg(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            stop_run($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic compare_stat(input string name, input uplink_reg_pkg::uplink_stat_t exp,
                                input uplink_reg_pkg::uplink_stat_t act);
        if (act !== exp) begin
            stop_run($sformatf("[FAIL] %s: expected sent %0d dropped %0d, actual sent %0d dropped %0d",
                               name, exp.frames_sent, exp.frames_dropped,
                               act.frames_sent, act.frames_dropped));
        end
    endtask

    // STATUS register keeps frames_sent in the low half
    function automatic uplink_reg_pkg::uplink_stat_t status_from_reg(input logic [31:0] r);
        uplink_reg_pkg::uplink_stat_t s;
        s.frames_sent    = r[15:0];
        s.frames_dropped = r[31:16];
        return s;
    endfunction

    // --------------------------------------------------
    // APB access and stimulus
    // --------------------------------------------------
    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
        int n;
        @(posedge clk_sys);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk_sys);
        penable <= 1'b1;
        n = 0;
        @(negedge clk_sys);
        while (!pready) begin
            n++;
            if (n > APB_TIMEOUT) stop_run("APB write never saw pready");
            @(negedge clk_sys);
        end
        err = pslverr;
        @(posedge clk_sys);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] rdata, output logic err);
        int n;
        @(posedge clk_sys);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk_sys);
        penable <= 1'b1;
        n = 0;
        @(negedge clk_sys);
        while (!pready) begin
            n++;
            if (n > APB_TIMEOUT) stop_run("APB read never saw pready");
            @(negedge clk_sys);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk_sys);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic reset_dut();
        @(posedge clk_sys);
        rst_sys_n <= 1'b0;
        repeat (5) @(posedge clk_sys);
        rst_sys_n <= 1'b1;
    endtask

    task automatic randomize_inputs();
        logic [31:0] rnd;
        @(posedge clk_sys);
        rnd = $random(seed);
        mdu_status <= rnd;
        for (int c = 0; c < uplink_frame_pkg::N_CHN; c++) begin
            rnd = $random(seed);
            chn_samples[c].elec <= rnd;
            rnd = $random(seed);
            chn_samples[c].engn <= rnd;
            rnd = $random(seed);
            chn_samples[c].masb <= rnd[7:0];
        end
    endtask

    // --------------------------------------------------
    // Reference frame model
    // --------------------------------------------------
    function automatic logic [15:0] crc_word(input logic [15:0] crc_in, input logic [15:0] w);
        logic [15:0] c;
        logic        fb;
        c = crc_in;
        for (int i = 15; i >= 0; i--) begin
            fb = c[15] ^ w[i];
            c  = c << 1;
            if (fb) c = c ^ uplink_frame_pkg::CRC_POLY;
        end
        return c;
    endfunction

    task automatic model_frame();
        logic [7:0]                    pb [PAIR_BYTES];
        uplink_frame_pkg::chn_sample_t e;
        uplink_frame_pkg::chn_sample_t o;
        logic [15:0]                   crc;
        for (int i = 0; i < NW; i++) begin
            exp_words[i] = '0;
        end
        exp_words[0].sop  = 1'b1;
        exp_words[1].data = 16'h0004;
        exp_words[2].data = 16'(slot_val) << 2;
        exp_words[3].data = exp_seq;
        exp_words[4].data = uplink_frame_pkg::DATA_TYPE;
        exp_words[6].data = 16'(uplink_frame_pkg::PAYLOAD_WORDS);
        exp_words[7].data = mdu_status[15:0];
        exp_words[8].data = mdu_status[31:16];
        // Pair as a little endian byte stream, two bytes per word
        for (int p = 0; p < uplink_frame_pkg::N_CHN / 2; p++) begin
            e = chn_samples[2 * p];
            o = chn_samples[2 * p + 1];
            for (int k = 0; k < 4; k++) begin
                pb[k]      = e.elec[8 * k +: 8];
                pb[4 + k]  = e.engn[8 * k +: 8];
                pb[9 + k]  = o.elec[8 * k +: 8];
                pb[13 + k] = o.engn[8 * k +: 8];
            end
            pb[8]  = e.masb;
            pb[17] = o.masb;
            for (int k = 0; k < PAIR_BYTES / 2; k++) begin
                exp_words[uplink_frame_pkg::HDR_WORDS + p * PAIR_BYTES / 2 + k].data =
                    {pb[2 * k + 1], pb[2 * k]};
            end
        end
        crc = uplink_frame_pkg::CRC_INIT;
        for (int i = 7; i < NW - 1; i++) begin
            crc = crc_word(crc, exp_words[i].data);
        end
        exp_words[NW - 1].eop  = 1'b1;
        exp_words[NW - 1].data = crc;
    endtask

    // --------------------------------------------------
    // Stream collection
    // --------------------------------------------------
    // One word moves on each posedge after a negedge with valid and ready
    task automatic collect_frame(input string name);
        int   n;
        int   idle;
        logic done;
        n    = 0;
        done = 1'b0;
        while (!done) begin
            idle = 0;
            @(negedge clk_sys);
            while (!(out_valid && out_ready)) begin
                idle++;
                if (idle > WORD_TIMEOUT) begin
                    stop_run($sformatf("Timeout in %s waiting for word %0d", name, n));
                end
                @(negedge clk_sys);
            end
            if (n == NW) stop_run($sformatf("%s has no eop after %0d words", name, n));
            got_words[n] = out_word;
            n++;
            done = out_word.eop;
        end
        compare_reg({name, " length"}, 32'(NW), 32'(n));
    endtask

    task automatic check_frame(input string name);
        model_frame();
        for (int i = 0; i < NW; i++) begin
            compare_word($sformatf("%s word %0d", name, i), exp_words[i], got_words[i]);
        end
        exp_seq = exp_seq + 16'd1;
    endtask

    task automatic wait_for_valid(input int cycles, output logic seen);
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < cycles) begin
            @(negedge clk_sys);
            seen = out_valid;
            n++;
        end
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic test_registers();
        logic [31:0] rdata;
        logic        err;
        apb_read(uplink_reg_pkg::REG_CTRL, rdata, err);
        compare_reg("reset CTRL", 32'd0, rdata);
        apb_read(uplink_reg_pkg::REG_PERIOD, rdata, err);
        compare_reg("reset PERIOD", 32'(uplink_reg_pkg::PERIOD_RESET), rdata);
        apb_read(uplink_reg_pkg::REG_SLOT, rdata, err);
        compare_reg("reset SLOT", 32'd0, rdata);
        apb_read(uplink_reg_pkg::REG_STATUS, rdata, err);
        compare_stat("reset STATUS", '0, status_from_reg(rdata));
        apb_write(uplink_reg_pkg::REG_PERIOD, 32'(TEST_PERIOD), err);
        compare_reg("PERIOD write pslverr", 32'd0, {31'd0, err});
        apb_read(uplink_reg_pkg::REG_PERIOD, rdata, err);
        compare_reg("PERIOD readback", 32'(TEST_PERIOD), rdata);
        apb_write(uplink_reg_pkg::REG_SLOT, 32'd5, err);
        apb_read(uplink_reg_pkg::REG_SLOT, rdata, err);
        compare_reg("SLOT readback", 32'd5, rdata);
        slot_val = 4'd5;
        apb_write(uplink_reg_pkg::REG_STATUS, 32'h1234, err);
        compare_reg("STATUS write pslverr", 32'd1, {31'd0, err});
        apb_read(4'h2, rdata, err);
        compare_reg("unmapped read pslverr", 32'd1, {31'd0, err});
    endtask

    task automatic test_frame_format();
        logic err;
        randomize_inputs();
        out_ready <= 1'b1;
        apb_write(uplink_reg_pkg::REG_CTRL, 32'd1, err);
        collect_frame("frame_format");
        check_frame("frame_format");
    endtask

    task automatic test_sequence();
        logic [31:0]                  rdata;
        logic                         err;
        uplink_reg_pkg::uplink_stat_t exp;
        string                        name;
        reset_dut();
        exp_seq = 16'd0;
        apb_write(uplink_reg_pkg::REG_PERIOD, 32'(TEST_PERIOD), err);
        apb_write(uplink_reg_pkg::REG_SLOT, 32'd9, err);
        slot_val = 4'd9;
        randomize_inputs();
        apb_write(uplink_reg_pkg::REG_CTRL, 32'd1, err);
        // New inputs land between frames, well before the next tick
        for (int f = 0; f < 3; f++) begin
            name = $sformatf("sequence frame %0d", f);
            collect_frame(name);
            check_frame(name);
            randomize_inputs();
        end
        apb_read(uplink_reg_pkg::REG_STATUS, rdata, err);
        exp.frames_sent    = 16'd3;
        exp.frames_dropped = 16'd0;
        compare_stat("sequence STATUS", exp, status_from_reg(rdata));
    endtask

    task automatic test_backpressure();
        logic [31:0] rdata;
        logic        err;
        int          polls;
        string       name;
        @(posedge clk_sys);
        out_ready <= 1'b0;
        polls = 0;
        rdata = 32'd0;
        while (rdata[31:16] == 16'd0) begin
            polls++;
            if (polls > DROP_POLLS) stop_run("frames_dropped stayed zero while out_ready was low");
            apb_read(uplink_reg_pkg::REG_STATUS, rdata, err);
        end
        @(posedge clk_sys);
        out_ready <= 1'b1;
        for (int f = 0; f < 3; f++) begin
            name = $sformatf("backpressure frame %0d", f);
            collect_frame(name);
            check_frame(name);
        end
    endtask

    task automatic test_disable();
        logic [31:0] rdata;
        logic        err;
        logic        seen;
        @(posedge clk_sys);
        out_ready <= 1'b0;
        wait_for_valid(QUIET_CYCLES, seen);
        if (!seen) stop_run("No frame reached the output before disable");
        if (!out_word.sop) stop_run("Head word at a frame boundary carries no sop");
        apb_write(uplink_reg_pkg::REG_CTRL, 32'd0, err);
        // Frame in flight still finishes
        @(posedge clk_sys);
        out_ready <= 1'b1;
        collect_frame("disable frame");
        check_frame("disable frame");
        // Period timer stopped, output stays silent
        wait_for_valid(QUIET_CYCLES, seen);
        if (seen) stop_run("Output became valid again after enable was cleared");
        apb_read(uplink_reg_pkg::REG_STATUS, rdata, err);
        compare_reg("disable frames_sent", {16'd0, exp_seq}, {16'd0, rdata[15:0]});
    endtask

    initial begin
        seed       = 83287;
        exp_seq    = 16'd0;
        slot_val   = 4'd0;
        rst_sys_n  = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = 4'd0;
        pwdata     = 32'd0;
        mdu_status = 32'd0;
        out_ready  = 1'b0;
        for (int c = 0; c < uplink_frame_pkg::N_CHN; c++) begin
            chn_samples[c] = '0;
        end
        reset_dut();
        test_registers();
        test_frame_format();
        test_sequence();
        test_backpressure();
        test_disable();
        $display("All tests passed");
        $finish;
    end

endmodule

//--- hdl/uplink_top.sv
// -----------------------------------------------
// Uplink frame generator top
// Registers, frame builder, CRC and output FIFO
// -----------------------------------------------
`timescale 1ns/1ns

module uplink_top (
    input  logic                          clk_sys,
    input  logic                          rst_sys_n,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [3:0]                    paddr,
    input  logic [31:0]                   pwdata,
    output logic [31:0]                   prdata,
    output logic                          pready,
    output logic                          pslverr,
    input  logic [31:0]                   mdu_status,
    input  uplink_frame_pkg::chn_sample_t chn_samples [uplink_frame_pkg::N_CHN],
    input  logic                          out_ready,
    output logic                          out_valid,
    output uplink_frame_pkg::frame_word_t out_word
);

    uplink_reg_pkg::uplink_cfg_t   cfg;
    uplink_reg_pkg::uplink_stat_t  stat;
    uplink_frame_pkg::frame_word_t wr_word;
    uplink_frame_pkg::fifo_cnt_t   free_words;
    logic                          wr_en;
    logic                          crc_clear;
    logic                          crc_en;
    logic [15:0]                   crc_data;
    logic [15:0]                   crc_value;

    uplink_cfg_apb i_cfg (
        .clk_sys, .rst_sys_n,
        .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr,
        .stat, .cfg
    );

    frame_builder i_builder (
        .clk_sys, .rst_sys_n, .cfg, .mdu_status, .chn_samples, .free_words,
        .crc_value, .crc_clear, .crc_en, .crc_data, .wr_en, .wr_word, .stat
    );

    crc16_d16 i_crc (
        .clk_sys, .rst_sys_n, .crc_clear, .crc_en, .crc_data, .crc_value
    );

    frame_fifo i_fifo (
        .clk_sys, .rst_sys_n, .wr_en, .wr_word, .free_words,
        .out_ready, .out_valid, .out_word
    );

endmodule

//--- hdl/frame_builder.sv
// -----------------------------------------------
// Uplink frame builder
// Period timer, input snapshot and the header,
// payload and CRC word sequencer
// -----------------------------------------------
`timescale 1ns/1ns

module frame_builder (
    input  logic                          clk_sys,
    input  logic                          rst_sys_n,
    input  uplink_reg_pkg::uplink_cfg_t   cfg,
    input  logic [31:0]                   mdu_status,
    input  uplink_frame_pkg::chn_sample_t chn_samples [uplink_frame_pkg::N_CHN],
    input  uplink_frame_pkg::fifo_cnt_t   free_words,
    input  logic [15:0]                   crc_value,
    output logic                          crc_clear,
    output logic                          crc_en,
    output logic [15:0]                   crc_data,
    output logic                          wr_en,
    output uplink_frame_pkg::frame_word_t wr_word,
    output uplink_reg_pkg::uplink_stat_t  stat
);

    uplink_frame_pkg::build_state_e state;
    uplink_frame_pkg::word_idx_t    word_idx;
    uplink_frame_pkg::chn_sample_t  snap_chn [uplink_frame_pkg::N_CHN];
    logic [31:0]                    snap_status;
    logic [3:0]                     snap_slot;
    logic [15:0]                    seq_num;
    logic [15:0]                    period_cnt;
    logic [15:0]                    word_data;
    logic                           tick;
    logic                           has_room;

    // Byte straddling layout of one even/odd channel pair
    function automatic logic [15:0] pack_word(input uplink_frame_pkg::chn_sample_t e,
                                              input uplink_frame_pkg::chn_sample_t o,
                                              input int k);
        logic [15:0] w;
        case (k)
            0:       w = e.elec[15:0];
            1:       w = e.elec[31:16];
            2:       w = e.engn[15:0];
            3:       w = e.engn[31:16];
            4:       w = {o.elec[7:0], e.masb};
            5:       w = o.elec[23:8];
            6:       w = {o.engn[7:0], o.elec[31:24]};
            7:       w = o.engn[23:8];
            default: w = {o.masb, o.engn[31:24]};
        endcase
        return w;
    endfunction

    // -----------------------------------------------
    // Period timer and frame admission
    // -----------------------------------------------
    assign tick     = cfg.enable && (period_cnt == cfg.period - 16'd1);
    assign has_room = free_words >= uplink_frame_pkg::fifo_cnt_t'(uplink_frame_pkg::FRAME_WORDS);

    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            period_cnt <= 16'd0;
        end else if (!cfg.enable || tick) begin
            period_cnt <= 16'd0;
        end else begin
            period_cnt <= period_cnt + 16'd1;
        end
    end

    // Snapshot taken once per accepted frame
    always_ff @(posedge clk_sys) begin
        if (tick && state == uplink_frame_pkg::IDLE && has_room) begin
            snap_chn    <= chn_samples;
            snap_status <= mdu_status;
            snap_slot   <= cfg.slot;
            seq_num     <= stat.frames_sent;
        end
    end

    // -----------------------------------------------
    // Word sequencer and counters
    // -----------------------------------------------
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            state               <= uplink_frame_pkg::IDLE;
            word_idx            <= '0;
            stat.frames_sent    <= 16'd0;
            stat.frames_dropped <= 16'd0;
        end else begin
            case (state)
                uplink_frame_pkg::IDLE: begin
                    word_idx <= '0;
                    if (tick && has_room) begin
                        state <= uplink_frame_pkg::HEADER;
                    end else if (tick) begin
                        stat.frames_dropped <= stat.frames_dropped + 16'd1;
                    end
                end
                uplink_frame_pkg::HEADER: begin
                    word_idx <= word_idx + 1'b1;
                    if (word_idx == uplink_frame_pkg::word_idx_t'(uplink_frame_pkg::PAY_FIRST - 1)) begin
                        state <= uplink_frame_pkg::PAYLOAD;
                    end
                end
                uplink_frame_pkg::PAYLOAD: begin
                    word_idx <= word_idx + 1'b1;
                    if (word_idx == uplink_frame_pkg::word_idx_t'(uplink_frame_pkg::PAY_LAST)) begin
                        state <= uplink_frame_pkg::CRC;
                    end
                end
                default: begin
                    state            <= uplink_frame_pkg::IDLE;
                    stat.frames_sent <= stat.frames_sent + 16'd1;
                end
            endcase
        end
    end

    // Data field for the current word
    always_comb begin
        int pay;
        int pair;
        pay       = int'(word_idx) - uplink_frame_pkg::PAY_FIRST;
        pair      = pay / uplink_frame_pkg::PAIR_WORDS;
        word_data = 16'd0;
        case (state)
            uplink_frame_pkg::HEADER: begin
                case (word_idx)
                    1:       word_data = uplink_frame_pkg::HDR_DA_SA;
                    2:       word_data = {10'd0, snap_slot, 2'b00};
                    3:       word_data = seq_num;
                    4:       word_data = uplink_frame_pkg::DATA_TYPE;
                    6:       word_data = 16'(uplink_frame_pkg::PAYLOAD_WORDS);
                    7:       word_data = snap_status[15:0];
                    8:       word_data = snap_status[31:16];
                    default: word_data = 16'd0;
                endcase
            end
            uplink_frame_pkg::PAYLOAD: begin
                word_data = pack_word(snap_chn[2 * pair], snap_chn[2 * pair + 1],
                                      pay % uplink_frame_pkg::PAIR_WORDS);
            end
            uplink_frame_pkg::CRC: word_data = crc_value;
            default: word_data = 16'd0;
        endcase
    end

    assign wr_en        = (state != uplink_frame_pkg::IDLE);
    assign wr_word.sop  = (state == uplink_frame_pkg::HEADER) && (word_idx == '0);
    assign wr_word.eop  = (state == uplink_frame_pkg::CRC);
    assign wr_word.data = word_data;

    // CRC covers the status words and the payload
    assign crc_clear = wr_word.sop;
    assign crc_en    = (state == uplink_frame_pkg::PAYLOAD) ||
                       ((state == uplink_frame_pkg::HEADER) && word_idx >= 7);
    assign crc_data  = word_data;

endmodule

//--- hdl/uplink_cfg_apb.sv
// -----------------------------------------------
// Uplink configuration registers
// APB slave for control, period and slot, with
// read back of the frame counters
// -----------------------------------------------
`timescale 1ns/1ns

module uplink_cfg_apb (
    input  logic                       clk_sys,
    input  logic                       rst_sys_n,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [3:0]                 paddr,
    input  logic [31:0]                pwdata,
    output logic [31:0]                prdata,
    output logic                       pready,
    output logic                       pslverr,
    input  uplink_reg_pkg::uplink_stat_t stat,
    output uplink_reg_pkg::uplink_cfg_t  cfg
);

    logic access;
    logic addr_ok;

    assign access  = psel && penable;
    assign addr_ok = (paddr == uplink_reg_pkg::REG_CTRL)   ||
                     (paddr == uplink_reg_pkg::REG_PERIOD) ||
                     (paddr == uplink_reg_pkg::REG_SLOT)   ||
                     (paddr == uplink_reg_pkg::REG_STATUS);

    // No wait states
    assign pready  = 1'b1;
    assign pslverr = access && (!addr_ok || (pwrite && paddr == uplink_reg_pkg::REG_STATUS));

    // Writes land on the access phase edge
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            cfg.enable <= 1'b0;
            cfg.period <= uplink_reg_pkg::PERIOD_RESET;
            cfg.slot   <= 4'd0;
        end else if (access && pwrite) begin
            case (paddr)
                uplink_reg_pkg::REG_CTRL:   cfg.enable <= pwdata[0];
                uplink_reg_pkg::REG_PERIOD: cfg.period <= pwdata[15:0];
                uplink_reg_pkg::REG_SLOT:   cfg.slot   <= pwdata[3:0];
                default: ;
            endcase
        end
    end

    // Read mux
    always_comb begin
        case (paddr)
            uplink_reg_pkg::REG_CTRL:   prdata = {31'd0, cfg.enable};
            uplink_reg_pkg::REG_PERIOD: prdata = {16'd0, cfg.period};
            uplink_reg_pkg::REG_SLOT:   prdata = {28'd0, cfg.slot};
            uplink_reg_pkg::REG_STATUS: prdata = {stat.frames_dropped, stat.frames_sent};
            default:                    prdata = 32'd0;
        endcase
    end

endmodule

//--- hdl/frame_fifo.sv
// -----------------------------------------------
// Frame word FIFO
// Circular buffer with free space count and a
// valid/ready output port
// -----------------------------------------------
`timescale 1ns/1ns

module frame_fifo (
    input  logic                          clk_sys,
    input  logic                          rst_sys_n,
    input  logic                          wr_en,
    input  uplink_frame_pkg::frame_word_t wr_word,
    output uplink_frame_pkg::fifo_cnt_t   free_words,
    input  logic                          out_ready,
    output logic                          out_valid,
    output uplink_frame_pkg::frame_word_t out_word
);

    uplink_frame_pkg::frame_word_t mem [uplink_frame_pkg::FIFO_DEPTH];
    logic [uplink_frame_pkg::FIFO_AW-1:0] wr_ptr;
    logic [uplink_frame_pkg::FIFO_AW-1:0] rd_ptr;
    uplink_frame_pkg::fifo_cnt_t          count;
    logic                                 push;
    logic                                 pop;

    assign push = wr_en && (free_words != '0);
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk_sys) begin
        if (push) begin
            mem[wr_ptr] <= wr_word;
        end
    end

    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + push;
            rd_ptr <= rd_ptr + pop;
            count  <= count + push - pop;
        end
    end

    // Head word stays put until it is taken
    assign out_valid  = (count != '0);
    assign out_word   = mem[rd_ptr];
    assign free_words = uplink_frame_pkg::fifo_cnt_t'(uplink_frame_pkg::FIFO_DEPTH) - count;

endmodule

//--- hdl/crc16_d16.sv
// -----------------------------------------------
// CRC-16 accumulator
// Folds in one 16-bit word per clock, MSB first
// -----------------------------------------------
`timescale 1ns/1ns

module crc16_d16 (
    input  logic        clk_sys,
    input  logic        rst_sys_n,
    input  logic        crc_clear,
    input  logic        crc_en,
    input  logic [15:0] crc_data,
    output logic [15:0] crc_value
);

    logic [15:0] crc_next;

    // Sixteen serial shift steps in one cycle
    always_comb begin
        crc_next = crc_value;
        for (int i = 15; i >= 0; i--) begin
            if (crc_next[15] ^ crc_data[i]) begin
                crc_next = {crc_next[14:0], 1'b0} ^ uplink_frame_pkg::CRC_POLY;
            end else begin
                crc_next = {crc_next[14:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            crc_value <= uplink_frame_pkg::CRC_INIT;
        end else if (crc_clear) begin
            crc_value <= uplink_frame_pkg::CRC_INIT;
        end else if (crc_en) begin
            crc_value <= crc_next;
        end
    end

endmodule

//--- hdl/uplink_reg_pkg.sv
// -----------------------------------------------
// Uplink register map
// APB addresses, reset values, config and status
// -----------------------------------------------
package uplink_reg_pkg;

    // Register addresses
    localparam logic [3:0] REG_CTRL   = 4'h0;
    localparam logic [3:0] REG_PERIOD = 4'h4;
    localparam logic [3:0] REG_SLOT   = 4'h8;
    localparam logic [3:0] REG_STATUS = 4'hC;

    // Frame period in clk_sys cycles after reset
    localparam logic [15:0] PERIOD_RESET = 16'd200;

    typedef struct packed {
        logic        enable;
        logic [15:0] period;
        logic [3:0]  slot;
    } uplink_cfg_t;

    // Read back through REG_STATUS
    typedef struct packed {
        logic [15:0] frames_sent;
        logic [15:0] frames_dropped;
    } uplink_stat_t;

endpackage

//--- hdl/uplink_frame_pkg.sv
// -----------------------------------------------
// Uplink frame format
// Frame layout constants, stream word and channel
// sample types, sequencer states
// -----------------------------------------------
package uplink_frame_pkg;

    // Frame layout
    localparam int N_CHN         = 4;
    localparam int HDR_WORDS     = 9;
    localparam int PAIR_WORDS    = 9;
    localparam int PAYLOAD_WORDS = PAIR_WORDS * (N_CHN / 2);
    localparam int FRAME_WORDS   = HDR_WORDS + PAYLOAD_WORDS + 1;
    localparam int PAY_FIRST     = HDR_WORDS;
    localparam int PAY_LAST      = HDR_WORDS + PAYLOAD_WORDS - 1;
    localparam int IDX_W         = $clog2(FRAME_WORDS);

    // Header field values
    localparam logic [15:0] HDR_DA_SA = 16'h0004;
    localparam logic [15:0] DATA_TYPE = 16'h0010;

    // CRC-16 CCITT style, no reflection
    localparam logic [15:0] CRC_POLY = 16'h1021;
    localparam logic [15:0] CRC_INIT = 16'hFFFF;

    // Output buffer
    localparam int FIFO_DEPTH = 64;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

    typedef logic [FIFO_AW:0]   fifo_cnt_t;
    typedef logic [IDX_W-1:0]   word_idx_t;

    typedef struct packed {
        logic        sop;
        logic        eop;
        logic [15:0] data;
    } frame_word_t;

    typedef struct packed {
        logic [31:0] elec;
        logic [31:0] engn;
        logic [7:0]  masb;
    } chn_sample_t;

    typedef enum logic [1:0] {IDLE, HEADER, PAYLOAD, CRC} build_state_e;

endpackage
